// File: logic/csr_map_pkg.sv
package csr_map_pkg;

    localparam int XLEN       = 64;
    localparam int CSR_ADDR_W = 12;
    localparam int INSTR_W    = 32;

    typedef enum logic [CSR_ADDR_W-1:0] {
        csr_mvendorid = 12'hf11,
        csr_marchid   = 12'hf12,
        csr_mimpid    = 12'hf13,
        csr_mhartid   = 12'hf14,
        csr_mstatus   = 12'h300,
        csr_misa      = 12'h301,
        csr_mie       = 12'h304,
        csr_mtvec     = 12'h305,
        csr_mscratch  = 12'h340,
        csr_mepc      = 12'h341,
        csr_mcause    = 12'h342,
        csr_mtval     = 12'h343,
        csr_mip       = 12'h344,
        csr_mtinst    = 12'h34a,
        csr_mtimecmp  = 12'hbbf,
        csr_cycle     = 12'hc00,
        csr_time      = 12'hc01
    } csr_addr_e;

    typedef enum logic [1:0] {
        csr_op_write = 2'h1,
        csr_op_set   = 2'h2,
        csr_op_clear = 2'h3
    } csr_op_e;

    // mxl=2, extensions a c i m s u
    localparam logic [XLEN-1:0] MISA_VALUE = 64'h8000_0000_0014_1105;

endpackage

// File: logic/csr_trap_pkg.sv
package csr_trap_pkg;

    typedef enum logic [62:0] {
        cause_misaligned = 63'd0,
        cause_illegal    = 63'd2,
        cause_ebreak     = 63'd3,
        cause_lw_fault   = 63'd5,
        cause_sw_fault   = 63'd7,
        cause_ecall      = 63'd11
    } cause_code_e;

    // interrupt codes share values with exception codes
    localparam cause_code_e IRQ_M_TIMER    = cause_sw_fault;
    localparam cause_code_e IRQ_M_EXTERNAL = cause_ecall;

    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;

    // same positions in mie and mip
    localparam int MIE_MTIE = 7;
    localparam int MIE_MEIE = 11;

    localparam logic [1:0] PRIV_M = 2'b11;

    localparam logic [1:0] MTVEC_VECTORED = 2'd1;

    typedef struct packed {
        logic        interrupt;
        cause_code_e code;
    } mcause_fields_t;

    typedef union packed {
        logic [63:0]    raw;
        mcause_fields_t f;
    } mcause_u;

    typedef struct packed {
        logic [61:0] base;
        logic [1:0]  mode;
    } mtvec_fields_t;

    typedef union packed {
        logic [63:0]   raw;
        mtvec_fields_t f;
    } mtvec_u;

endpackage

// File: logic/csr_trap_if.sv
interface csr_trap_if;
    import csr_map_pkg::*;
    import csr_trap_pkg::*;

    logic            valid;
    logic            is_interrupt;
    cause_code_e     code;
    logic [XLEN-1:0] epc;
    logic [XLEN-1:0] tval;
    logic [XLEN-1:0] tinst;

    modport ctrl (
        output valid,
        output is_interrupt,
        output code,
        output epc,
        output tval,
        output tinst
    );

    modport regs (
        input valid,
        input is_interrupt,
        input code,
        input epc,
        input tval,
        input tinst
    );

endinterface

// File: logic/csr_trap_ctrl.sv
module csr_trap_ctrl (
    input  logic                            i_csr_unit_clk,
    input  logic                            i_csr_unit_rst_n,
    input  logic [csr_map_pkg::XLEN-1:0]    i_pc,
    input  logic [csr_map_pkg::INSTR_W-1:0] i_instr,
    input  logic [csr_map_pkg::XLEN-1:0]    i_fault_addr,
    input  logic                            i_illegal_id,
    input  logic                            i_illegal_exe,
    input  logic                            i_misaligned,
    input  logic                            i_ecall,
    input  logic                            i_ebreak,
    input  logic                            i_lw_fault,
    input  logic                            i_sw_fault,
    input  logic                            i_mret,
    input  logic                            i_mstatus_mie,
    input  logic [csr_map_pkg::XLEN-1:0]    i_mie_bits,
    input  logic [csr_map_pkg::XLEN-1:0]    i_mip_bits,
    output logic                            o_setting_up,
    output logic                            o_ack,
    output logic                            o_if_flush,
    output logic                            o_id_flush,
    output logic                            o_exe_flush,
    output logic                            o_mem_flush,
    csr_trap_if.ctrl                        trap
);
    import csr_map_pkg::*;
    import csr_trap_pkg::*;

    typedef enum logic {st_idle, st_setting_up} state_e;

    state_e state;
    logic   ext_irq;
    logic   tmr_irq;
    logic   pending_exception;

    assign ext_irq = i_mstatus_mie & i_mie_bits[MIE_MEIE] & i_mip_bits[MIE_MEIE];
    assign tmr_irq = i_mstatus_mie & i_mie_bits[MIE_MTIE] & i_mip_bits[MIE_MTIE];
    assign pending_exception = i_illegal_id | i_illegal_exe | i_misaligned | i_ecall | i_ebreak;

    // highest priority cause first
    always_comb
    begin
        trap.is_interrupt = 1'b0;
        trap.code         = cause_misaligned;
        trap.tval         = '0;
        if (ext_irq)
        begin
            trap.is_interrupt = 1'b1;
            trap.code         = IRQ_M_EXTERNAL;
        end
        else if (tmr_irq)
        begin
            trap.is_interrupt = 1'b1;
            trap.code         = IRQ_M_TIMER;
        end
        else if (i_illegal_id | i_illegal_exe)
            trap.code = cause_illegal;
        else if (i_misaligned)
            trap.code = cause_misaligned;
        else if (i_ecall)
            trap.code = cause_ecall;
        else if (i_ebreak)
            trap.code = cause_ebreak;
        else if (i_sw_fault)
        begin
            trap.code = cause_sw_fault;
            trap.tval = i_fault_addr;
        end
        else if (i_lw_fault)
        begin
            trap.code = cause_lw_fault;
            trap.tval = i_fault_addr;
        end
    end

    assign trap.valid = (state == st_idle) &
                        (ext_irq | tmr_irq | pending_exception | i_lw_fault | i_sw_fault);
    assign trap.epc   = i_pc;
    assign trap.tinst = trap.is_interrupt ? '0 : XLEN'(i_instr);

    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
        begin
            state <= st_idle;
            o_ack <= 1'b0;
        end
        else
        begin
            o_ack <= trap.valid & trap.is_interrupt;    // drops again after setting_up
            if (state == st_setting_up)
                state <= st_idle;
            else if (trap.valid)
                state <= st_setting_up;
        end
    end

    assign o_setting_up = (state == st_setting_up);

    assign o_mem_flush = i_lw_fault | i_sw_fault | i_mret;
    assign o_exe_flush = o_mem_flush | i_illegal_exe | i_misaligned;
    assign o_id_flush  = o_exe_flush | pending_exception;
    assign o_if_flush  = pending_exception | o_setting_up | i_mret;

endmodule

// File: logic/csr_machine_regs.sv
module csr_machine_regs #(
    parameter logic [csr_map_pkg::XLEN-1:0] p_hart_id = '0
) (
    input  logic                         i_csr_unit_clk,
    input  logic                         i_csr_unit_rst_n,
    input  logic                         i_csr_wen,
    input  csr_map_pkg::csr_op_e         i_op,
    input  logic [csr_map_pkg::XLEN-1:0] i_src,
    input  csr_map_pkg::csr_addr_e       i_addr,
    input  logic                         i_mret,
    input  logic                         i_mexternal,
    input  logic                         i_setting_up,
    csr_trap_if.regs                     trap,
    output logic [csr_map_pkg::XLEN-1:0] o_rdata,
    output logic                         o_mstatus_mie,
    output logic [csr_map_pkg::XLEN-1:0] o_mie_bits,
    output logic [csr_map_pkg::XLEN-1:0] o_mip_bits,
    output csr_trap_pkg::mtvec_u         o_mtvec,
    output csr_trap_pkg::mcause_u        o_mcause,
    output logic [csr_map_pkg::XLEN-1:0] o_mepc
);
    import csr_map_pkg::*;
    import csr_trap_pkg::*;

    logic            status_mie;
    logic            status_mpie;
    logic [XLEN-1:0] mie;
    logic            meip;
    logic            mtip;
    mtvec_u          mtvec;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    mcause_u         mcause;
    logic [XLEN-1:0] mtval;
    logic [XLEN-1:0] mtinst;
    logic [XLEN-1:0] mtimecmp;
    logic [XLEN-1:0] counter;   // read as cycle and time

    logic [XLEN-1:0] mstatus_rd;
    logic [XLEN-1:0] mip_rd;
    logic [XLEN-1:0] op_result;

    always_comb
    begin
        mstatus_rd                      = '0;
        mstatus_rd[MSTATUS_MIE]         = status_mie;
        mstatus_rd[MSTATUS_MPIE]        = status_mpie;
        mstatus_rd[MSTATUS_MPP_LO +: 2] = PRIV_M;   // no other mode
        mip_rd                          = '0;
        mip_rd[MIE_MEIE]                = meip;
        mip_rd[MIE_MTIE]                = mtip;
    end

    always_comb
    begin
        case (i_addr)
            csr_mhartid:  o_rdata = p_hart_id;
            csr_mstatus:  o_rdata = mstatus_rd;
            csr_misa:     o_rdata = MISA_VALUE;
            csr_mie:      o_rdata = mie;
            csr_mtvec:    o_rdata = mtvec.raw;
            csr_mscratch: o_rdata = mscratch;
            csr_mepc:     o_rdata = mepc;
            csr_mcause:   o_rdata = mcause.raw;
            csr_mtval:    o_rdata = mtval;
            csr_mip:      o_rdata = mip_rd;
            csr_mtinst:   o_rdata = mtinst;
            csr_mtimecmp: o_rdata = mtimecmp;
            csr_cycle,
            csr_time:     o_rdata = counter;
            default:      o_rdata = '0;  // vendor, arch and impl ids too
        endcase
    end

    always_comb
    begin
        case (i_op)
            csr_op_write: op_result = i_src;
            csr_op_set:   op_result = o_rdata | i_src;
            csr_op_clear: op_result = o_rdata & ~i_src;
            default:      op_result = o_rdata;
        endcase
    end

    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
        begin
            status_mie  <= 1'b0;
            status_mpie <= 1'b0;
            mie         <= '0;
            mtvec       <= '0;
            mscratch    <= '0;
            mepc        <= '0;
            mcause      <= '0;
            mtval       <= '0;
            mtinst      <= '0;
            mtimecmp    <= '0;
        end
        else if (i_csr_wen && i_mret)
        begin
            status_mie  <= status_mpie;
            status_mpie <= 1'b1;
        end
        else if (i_csr_wen)
        begin
            case (i_addr)
                csr_mstatus:
                begin
                    status_mie  <= op_result[MSTATUS_MIE];
                    status_mpie <= op_result[MSTATUS_MPIE];
                end
                csr_mie:      mie        <= op_result;
                csr_mtvec:    mtvec.raw  <= op_result;
                csr_mscratch: mscratch   <= op_result;
                csr_mepc:     mepc       <= op_result;
                csr_mcause:   mcause.raw <= op_result;
                csr_mtval:    mtval      <= op_result;
                csr_mtinst:   mtinst     <= op_result;
                csr_mtimecmp: mtimecmp   <= op_result;
                default:      ;
            endcase
        end
        else if (trap.valid)
        begin
            mepc                <= trap.epc;
            mcause.f.interrupt  <= trap.is_interrupt;
            mcause.f.code       <= trap.code;
            mtval               <= trap.tval;
            mtinst              <= trap.tinst;
        end
        else if (i_setting_up)
        begin
            status_mpie <= status_mie;
            status_mie  <= 1'b0;
        end
    end

    // pending bits lag their source by a cycle
    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
        begin
            meip    <= 1'b0;
            mtip    <= 1'b0;
            counter <= '0;
        end
        else
        begin
            meip    <= i_mexternal;
            mtip    <= (counter >= mtimecmp);
            counter <= counter + 1'b1;
        end
    end

    assign o_mstatus_mie = status_mie;
    assign o_mie_bits    = mie;
    assign o_mip_bits    = mip_rd;
    assign o_mtvec       = mtvec;
    assign o_mcause      = mcause;
    assign o_mepc        = mepc;

endmodule

// File: logic/csr_redirect.sv
module csr_redirect (
    input  csr_trap_pkg::mtvec_u         i_mtvec,
    input  csr_trap_pkg::mcause_u        i_mcause,
    input  logic [csr_map_pkg::XLEN-1:0] i_mepc,
    input  logic                         i_mret,
    input  logic                         i_setting_up,
    output logic [csr_map_pkg::XLEN-1:0] o_irq_handler,
    output logic [csr_map_pkg::XLEN-1:0] o_rtrn_addr,
    output logic                         o_addr_ctrl,
    output logic                         o_mux1
);
    import csr_map_pkg::*;
    import csr_trap_pkg::*;

    logic [XLEN-1:0] base;
    logic [XLEN-1:0] vec_offset;

    assign base       = {i_mtvec.f.base, 2'b00};
    assign vec_offset = {1'b0, i_mcause.f.code} << 2;

    // exceptions always land on the base
    always_comb
    begin
        if (i_mtvec.f.mode == MTVEC_VECTORED && i_mcause.f.interrupt)
            o_irq_handler = base + vec_offset;
        else
            o_irq_handler = base;
    end

    assign o_rtrn_addr = i_mepc;
    assign o_addr_ctrl = i_mret;                // pick mepc over handler
    assign o_mux1      = i_setting_up | i_mret;

endmodule

// File: logic/riscv_core_csr_unit.sv
module riscv_core_csr_unit #(
    parameter logic [csr_map_pkg::XLEN-1:0] p_hart_id = '0
) (
    input  logic                               i_csr_unit_clk,
    input  logic                               i_csr_unit_rst_n,
    input  logic [csr_map_pkg::XLEN-1:0]       i_csr_unit_pc,
    input  logic [csr_map_pkg::XLEN-1:0]       i_csr_unit_fault_addr,
    input  logic [csr_map_pkg::INSTR_W-1:0]    i_csr_unit_instr,
    input  logic                               i_csr_unit_mexternal,
    output logic                               o_csr_unit_ack,
    input  logic                               i_csr_unit_csr_wen,
    input  logic [1:0]                         i_csr_unit_op,
    input  logic [csr_map_pkg::XLEN-1:0]       i_csr_unit_src,
    input  logic [csr_map_pkg::CSR_ADDR_W-1:0] i_csr_unit_csr_addr,
    output logic [csr_map_pkg::XLEN-1:0]       o_csr_unit_csr_rdata,
    output logic [csr_map_pkg::XLEN-1:0]       o_csr_unit_irq_handler,
    output logic [csr_map_pkg::XLEN-1:0]       o_csr_unit_rtrn_addr,
    output logic                               o_csr_unit_addr_ctrl,
    output logic                               o_csr_unit_mux1,
    input  logic                               i_csr_unit_mret_wb,
    input  logic                               i_csr_unit_ecall,
    input  logic                               i_csr_unit_ebreak,
    input  logic                               i_csr_unit_illegal_instr_id,
    input  logic                               i_csr_unit_illegal_instr_exe,
    input  logic                               i_csr_unit_instr_addr_misaligned,
    input  logic                               i_csr_unit_lw_access_fault,
    input  logic                               i_csr_unit_sw_access_fault,
    output logic                               o_csr_unit_if_flush,
    output logic                               o_csr_unit_id_flush,
    output logic                               o_csr_unit_exe_flush,
    output logic                               o_csr_unit_mem_flush
);
    import csr_map_pkg::*;
    import csr_trap_pkg::*;

    logic            setting_up;
    logic            mstatus_mie;
    logic [XLEN-1:0] mie_bits;
    logic [XLEN-1:0] mip_bits;
    mtvec_u          mtvec;
    mcause_u         mcause;
    logic [XLEN-1:0] mepc;

    csr_trap_if trap_if_i ();

    csr_trap_ctrl trap_ctrl_i (
        .i_csr_unit_clk   (i_csr_unit_clk),
        .i_csr_unit_rst_n (i_csr_unit_rst_n),
        .i_pc             (i_csr_unit_pc),
        .i_instr          (i_csr_unit_instr),
        .i_fault_addr     (i_csr_unit_fault_addr),
        .i_illegal_id     (i_csr_unit_illegal_instr_id),
        .i_illegal_exe    (i_csr_unit_illegal_instr_exe),
        .i_misaligned     (i_csr_unit_instr_addr_misaligned),
        .i_ecall          (i_csr_unit_ecall),
        .i_ebreak         (i_csr_unit_ebreak),
        .i_lw_fault       (i_csr_unit_lw_access_fault),
        .i_sw_fault       (i_csr_unit_sw_access_fault),
        .i_mret           (i_csr_unit_mret_wb),
        .i_mstatus_mie    (mstatus_mie),
        .i_mie_bits       (mie_bits),
        .i_mip_bits       (mip_bits),
        .o_setting_up     (setting_up),
        .o_ack            (o_csr_unit_ack),
        .o_if_flush       (o_csr_unit_if_flush),
        .o_id_flush       (o_csr_unit_id_flush),
        .o_exe_flush      (o_csr_unit_exe_flush),
        .o_mem_flush      (o_csr_unit_mem_flush),
        .trap             (trap_if_i)
    );

    csr_machine_regs #(
        .p_hart_id (p_hart_id)
    ) machine_regs_i (
        .i_csr_unit_clk   (i_csr_unit_clk),
        .i_csr_unit_rst_n (i_csr_unit_rst_n),
        .i_csr_wen        (i_csr_unit_csr_wen),
        .i_op             (csr_op_e'(i_csr_unit_op)),
        .i_src            (i_csr_unit_src),
        .i_addr           (csr_addr_e'(i_csr_unit_csr_addr)),
        .i_mret           (i_csr_unit_mret_wb),
        .i_mexternal      (i_csr_unit_mexternal),
        .i_setting_up     (setting_up),
        .trap             (trap_if_i),
        .o_rdata          (o_csr_unit_csr_rdata),
        .o_mstatus_mie    (mstatus_mie),
        .o_mie_bits       (mie_bits),
        .o_mip_bits       (mip_bits),
        .o_mtvec          (mtvec),
        .o_mcause         (mcause),
        .o_mepc           (mepc)
    );

    csr_redirect redirect_i (
        .i_mtvec       (mtvec),
        .i_mcause      (mcause),
        .i_mepc        (mepc),
        .i_mret        (i_csr_unit_mret_wb),
        .i_setting_up  (setting_up),
        .o_irq_handler (o_csr_unit_irq_handler),
        .o_rtrn_addr   (o_csr_unit_rtrn_addr),
        .o_addr_ctrl   (o_csr_unit_addr_ctrl),
        .o_mux1        (o_csr_unit_mux1)
    );

endmodule

// File: testbench/csr_unit_checker.sv
module csr_unit_checker (
    input logic [63:0] i_rdata,
    input logic [63:0] i_irq_handler,
    input logic [63:0] i_rtrn_addr,
    input logic        i_ack,
    input logic        i_mux1,
    input logic        i_addr_ctrl,
    input logic        i_if_flush,
    input logic        i_id_flush,
    input logic        i_exe_flush,
    input logic        i_mem_flush
);
    localparam int SEL_RDATA   = 0;
    localparam int SEL_FLUSH   = 1;    // {if, id, exe, mem}
    localparam int SEL_CTRL    = 2;    // {ack, mux1, addr_ctrl}
    localparam int SEL_HANDLER = 3;
    localparam int SEL_RTRN    = 4;

    int passes = 0;
    int fails  = 0;

    function automatic logic [63:0] actual(input int sel);
        case (sel)
            SEL_RDATA:   return i_rdata;
            SEL_FLUSH:   return {60'b0, i_if_flush, i_id_flush, i_exe_flush, i_mem_flush};
            SEL_CTRL:    return {61'b0, i_ack, i_mux1, i_addr_ctrl};
            SEL_HANDLER: return i_irq_handler;
            SEL_RTRN:    return i_rtrn_addr;
            default:     return 64'b0;
        endcase
    endfunction

    // up to three checks per row, unused ones carry sel 7
    task automatic check_row(input string name, input int s0, input logic [63:0] e0,
                             input int s1, input logic [63:0] e1,
                             input int s2, input logic [63:0] e2);
        int          sel [3];
        logic [63:0] exp [3];
        logic [63:0] act;
        bit          bad;
        sel = '{s0, s1, s2};
        exp = '{e0, e1, e2};
        bad = 1'b0;
        for (int k = 0; k < 3; k++)
        begin
            if (sel[k] > SEL_RTRN)
                continue;
            act = actual(sel[k]);
            if (act !== exp[k])
            begin
                $display("ERR %s expected %h actual %h", name, exp[k], act);
                bad = 1'b1;
            end
        end
        if (bad)
            fails++;
        else
        begin
            passes++;
            $display("ok  %s", name);
        end
    endtask

    task automatic report_miss(input string name, input string what);
        $display("%s: %s", name, what);
        fails++;
    endtask

    task automatic print_summary();
        $display("%0d tests checked, %0d passed, %0d failed", passes + fails, passes, fails);
    endtask

endmodule

// File: testbench/csr_unit_tb.sv
module csr_unit_tb;
    import csr_map_pkg::*;

    localparam int PERIOD   = 10;
    localparam int MAX_ROWS = 48;
    localparam int ACK_WIN  = 8;
    localparam int NONE = 7, RDATA = 0, FLUSH = 1, CTRL = 2, HANDLER = 3, RTRN = 4;
    localparam logic [1:0] OP_W = 2'h1, OP_S = 2'h2, OP_C = 2'h3;
    // event bits of a row
    localparam logic [9:0] EV_ILL_ID = 10'h001, EV_LW = 10'h020, EV_MRET = 10'h080;
    localparam logic [9:0] EV_MEXT = 10'h100, EV_SRC_RD = 10'h200;
    localparam logic [63:0] TVEC_D = 64'h0000_0000_8000_0100;
    localparam logic [63:0] TVEC_V = 64'h0000_0000_8000_0201;

    logic        clk, rst_n, mext, csr_wen, mret, ecall, ebreak;
    logic        ill_id, ill_exe, misal, lw_fault, sw_fault;
    logic [1:0]  op;
    logic [11:0] addr;
    logic [31:0] instr;
    logic [63:0] pc, fault_addr, src;
    logic        ack, addr_ctrl, mux1, if_flush, id_flush, exe_flush, mem_flush;
    logic [63:0] rdata, irq_handler, rtrn_addr;

    string       t_name [MAX_ROWS];
    logic        t_wen [MAX_ROWS];
    logic [1:0]  t_op [MAX_ROWS];
    logic [11:0] t_addr [MAX_ROWS];
    logic [63:0] t_src [MAX_ROWS];
    logic [63:0] t_pc [MAX_ROWS];
    logic [9:0]  t_ev [MAX_ROWS];
    int          t_settle [MAX_ROWS];
    bit          t_wait [MAX_ROWS];
    int          t_sel [MAX_ROWS][3];
    logic [63:0] t_exp [MAX_ROWS][3];
    int          n_rows = 0;
    bit          table_ready = 1'b0;
    integer      seed = 32'h17dcf1eb;
    logic [63:0] r1, r2, r3, misa_exp, last_rdata;
    int          limit;
    int          waited;

    riscv_core_csr_unit #(.p_hart_id(64'd5)) dut_i (
        .i_csr_unit_clk(clk), .i_csr_unit_rst_n(rst_n),
        .i_csr_unit_pc(pc), .i_csr_unit_fault_addr(fault_addr), .i_csr_unit_instr(instr),
        .i_csr_unit_mexternal(mext), .o_csr_unit_ack(ack),
        .i_csr_unit_csr_wen(csr_wen), .i_csr_unit_op(op), .i_csr_unit_src(src),
        .i_csr_unit_csr_addr(addr), .o_csr_unit_csr_rdata(rdata),
        .o_csr_unit_irq_handler(irq_handler), .o_csr_unit_rtrn_addr(rtrn_addr),
        .o_csr_unit_addr_ctrl(addr_ctrl), .o_csr_unit_mux1(mux1),
        .i_csr_unit_mret_wb(mret), .i_csr_unit_ecall(ecall), .i_csr_unit_ebreak(ebreak),
        .i_csr_unit_illegal_instr_id(ill_id), .i_csr_unit_illegal_instr_exe(ill_exe),
        .i_csr_unit_instr_addr_misaligned(misal),
        .i_csr_unit_lw_access_fault(lw_fault), .i_csr_unit_sw_access_fault(sw_fault),
        .o_csr_unit_if_flush(if_flush), .o_csr_unit_id_flush(id_flush),
        .o_csr_unit_exe_flush(exe_flush), .o_csr_unit_mem_flush(mem_flush)
    );

    csr_unit_checker chk_i (
        .i_rdata(rdata), .i_irq_handler(irq_handler), .i_rtrn_addr(rtrn_addr),
        .i_ack(ack), .i_mux1(mux1), .i_addr_ctrl(addr_ctrl),
        .i_if_flush(if_flush), .i_id_flush(id_flush),
        .i_exe_flush(exe_flush), .i_mem_flush(mem_flush)
    );

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic add_row(input string name, input logic wen, input logic [1:0] o,
                           input logic [11:0] a, input logic [63:0] s, input logic [63:0] p,
                           input logic [9:0] ev, input int settle, input bit wait_ack,
                           input int s0, input logic [63:0] e0, input int s1,
                           input logic [63:0] e1, input int s2, input logic [63:0] e2);
        t_name[n_rows] = name;
        t_wen[n_rows] = wen;
        t_op[n_rows] = o;
        t_addr[n_rows] = a;
        t_src[n_rows] = s;
        t_pc[n_rows] = p;
        t_ev[n_rows] = ev;
        t_settle[n_rows] = settle;
        t_wait[n_rows] = wait_ack;
        t_sel[n_rows] = '{s0, s1, s2};
        t_exp[n_rows] = '{e0, e1, e2};
        n_rows++;
    endtask

    task automatic write_csr(input string name, input logic [1:0] o, input logic [11:0] a,
                             input logic [63:0] s);
        add_row(name, 1'b1, o, a, s, 64'h0, 10'h0, 0, 0, NONE, 0, NONE, 0, NONE, 0);
    endtask

    task automatic read_csr(input string name, input logic [11:0] a, input logic [63:0] e);
        add_row(name, 1'b0, OP_W, a, 64'h0, 64'h0, 10'h0, 0, 0, RDATA, e, NONE, 0, NONE, 0);
    endtask

    task automatic apply_row(input int i);
        csr_wen  <= t_wen[i];
        op       <= t_op[i];
        addr     <= t_addr[i];
        src      <= t_ev[i][9] ? (last_rdata >> 1) : t_src[i];   // below the counter
        if (t_pc[i] != 64'h0)
            pc <= t_pc[i];
        ill_id   <= t_ev[i][0];
        ill_exe  <= t_ev[i][1];
        misal    <= t_ev[i][2];
        ecall    <= t_ev[i][3];
        ebreak   <= t_ev[i][4];
        lw_fault <= t_ev[i][5];
        sw_fault <= t_ev[i][6];
        mret     <= t_ev[i][7];
        mext     <= t_ev[i][8];
    endtask

    // address, operand and pc stay put
    task automatic quiet_strobes();
        {csr_wen, ill_id, ill_exe, misal, ecall, ebreak} <= '0;
        {lw_fault, sw_fault, mret, mext} <= '0;
    endtask

    initial
    begin
        {rst_n, mext, csr_wen, mret, ecall, ebreak} = '0;
        {ill_id, ill_exe, misal, lw_fault, sw_fault} = '0;
        op = 2'h0;
        addr = 12'h0;
        src = 64'h0;
        pc = 64'h0;
        last_rdata = 64'h0;
        r1 = {$random(seed), $random(seed)};
        r2 = {$random(seed), $random(seed)};
        r3 = {$random(seed), $random(seed)};
        fault_addr = {$random(seed), $random(seed)};
        instr = $random(seed);
        misa_exp = (64'd2 << 62) | (64'd1 << 0) | (64'd1 << 2) | (64'd1 << 8)
                 | (64'd1 << 12) | (64'd1 << 18) | (64'd1 << 20);

        write_csr("w_mscratch", OP_W, csr_mscratch, r1);
        read_csr("rd_mscratch_write", csr_mscratch, r1);
        write_csr("s_mscratch", OP_S, csr_mscratch, r2);
        read_csr("rd_mscratch_set", csr_mscratch, r1 | r2);
        write_csr("c_mscratch", OP_C, csr_mscratch, r3);
        read_csr("rd_mscratch_clear", csr_mscratch, (r1 | r2) & ~r3);
        read_csr("rd_misa", csr_misa, misa_exp);
        read_csr("rd_mhartid", csr_mhartid, 64'd5);
        read_csr("rd_mvendorid", csr_mvendorid, 64'd0);

        write_csr("w_mtvec_direct", OP_W, csr_mtvec, TVEC_D);
        write_csr("s_mstatus_mie", OP_S, csr_mstatus, 64'h8);
        add_row("illegal_flush", 0, OP_W, csr_mcause, 0, 64'h1000, EV_ILL_ID, 0, 0,
                FLUSH, 64'b1100, NONE, 0, NONE, 0);
        add_row("illegal_setup", 0, OP_W, csr_mcause, 0, 0, 0, 0, 0,
                CTRL, 64'b010, HANDLER, TVEC_D & ~64'h3, RDATA, 64'd2);
        read_csr("illegal_mepc", csr_mepc, 64'h1000);
        read_csr("illegal_mtinst", csr_mtinst, {32'h0, instr});
        read_csr("illegal_mstatus", csr_mstatus, 64'h1880);   // mpp, mpie

        write_csr("w_mtvec_vectored", OP_W, csr_mtvec, TVEC_V);
        write_csr("s_mstatus_mie2", OP_S, csr_mstatus, 64'h8);
        write_csr("s_mie_meie", OP_S, csr_mie, 64'h800);
        add_row("ext_irq", 0, OP_W, csr_mcause, 0, 64'h2000, EV_MEXT, 0, 1,
                CTRL, 64'b110, HANDLER, (TVEC_V & ~64'h3) + 64'd44,
                RDATA, 64'h8000_0000_0000_000b);
        add_row("ext_ack_drop", 0, OP_W, csr_mstatus, 0, 0, 0, 0, 0,
                CTRL, 64'b000, RDATA, 64'h1880, NONE, 0);

        write_csr("s_mstatus_mie3", OP_S, csr_mstatus, 64'h8);
        add_row("lw_fault_flush", 0, OP_W, csr_mtval, 0, 64'h3000, EV_LW, 0, 0,
                FLUSH, 64'b0111, NONE, 0, NONE, 0);
        add_row("lw_fault_mtval", 0, OP_W, csr_mtval, 0, 0, 0, 0, 0,
                CTRL, 64'b010, RDATA, fault_addr, NONE, 0);
        read_csr("lw_fault_mcause", csr_mcause, 64'd5);

        add_row("mret", 1, OP_W, csr_mepc, 0, 0, EV_MRET, 0, 0,
                CTRL, 64'b011, RTRN, 64'h3000, FLUSH, 64'b1111);
        read_csr("mret_mstatus", csr_mstatus, 64'h1888);

        // compare value out of reach first, so mtip must drop
        write_csr("w_mtimecmp_max", OP_W, csr_mtimecmp, {64{1'b1}});
        add_row("rd_mip_clear", 0, OP_W, csr_mip, 0, 0, 0, 1, 0,
                RDATA, 64'h0, NONE, 0, NONE, 0);
        add_row("rd_cycle", 0, OP_W, csr_cycle, 0, 0, 0, 0, 0, NONE, 0, NONE, 0, NONE, 0);
        add_row("w_mtimecmp", 1, OP_W, csr_mtimecmp, 0, 0, EV_SRC_RD, 0, 0,
                NONE, 0, NONE, 0, NONE, 0);
        add_row("rd_mip_mtip", 0, OP_W, csr_mip, 0, 0, 0, 2, 0,
                RDATA, 64'h80, NONE, 0, NONE, 0);
        write_csr("s_mie_mtie", OP_S, csr_mie, 64'h80);
        add_row("timer_irq", 0, OP_W, csr_mcause, 0, 64'h4000, 0, 0, 1,
                CTRL, 64'b110, RDATA, 64'h8000_0000_0000_0007, NONE, 0);
        read_csr("timer_mepc", csr_mepc, 64'h4000);
        table_ready = 1'b1;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_rows; i++)
        begin
            @(posedge clk);
            apply_row(i);
            @(negedge clk);
            if (t_wait[i])
            begin
                waited = 0;
                while (!ack && waited < ACK_WIN)
                begin
                    @(posedge clk);
                    quiet_strobes();
                    @(negedge clk);
                    waited++;
                end
            end
            else
            begin
                repeat (t_settle[i])
                begin
                    @(posedge clk);
                    quiet_strobes();
                    @(negedge clk);
                end
            end
            last_rdata = rdata;
            if (t_wait[i] && !ack)
                chk_i.report_miss(t_name[i], "ack never seen within the wait window");
            else if (t_sel[i][0] != NONE)
                chk_i.check_row(t_name[i], t_sel[i][0], t_exp[i][0], t_sel[i][1],
                                t_exp[i][1], t_sel[i][2], t_exp[i][2]);
        end
        @(posedge clk);
        quiet_strobes();
        chk_i.print_summary();
        if (chk_i.fails == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial
    begin
        wait (table_ready);
        limit = (n_rows * (ACK_WIN + 3) + 20) * PERIOD;
        #(limit);
        $display("timeout: the test sequence did not finish in time");
        $display("tests failed");
        $finish;
    end

endmodule

// File: verilog.f
logic/csr_map_pkg.sv
logic/csr_trap_pkg.sv
logic/csr_trap_if.sv
logic/csr_trap_ctrl.sv
logic/csr_machine_regs.sv
logic/csr_redirect.sv
logic/riscv_core_csr_unit.sv
testbench/csr_unit_checker.sv
testbench/csr_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the csr unit testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing -Wno-fatal -f verilog.f --top-module csr_unit_tb \
    -o csr_unit_sim > build.log 2>&1 \
    && ./obj_dir/csr_unit_sim > sim.log 2>&1 \
    || { echo "build or run error"; cat build.log; exit 1; }

cat sim.log
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
